// File: dv/albuf_patterns.txt
// Columns: kind, byte address, word. Kind 00/01 memory word clean/bus error,
// 10/11 test target with full/random ready, 20 expected instruction, ff end
// Aligned 32-bit stream
00 00000000 00100093
00 00000004 00200113
00 00000008 00308193
00 0000000c 00410213
// Mixed stream with a split instruction at 0x12
00 00000010 05334501
00 00000014 808200b5
00 00000018 00000013
00 0000001c 45850001
// Upper-halfword target region
00 00000020 46051117
00 00000024 00c58633
00 00000028 80824681
00 0000002c 00000013
// Bus error on the word at 0x34
00 00000030 02931111
01 00000034 47050010
00 00000038 00000013
00 0000003c 80824501
// Test 1: aligned 32-bit instructions
10 00000000 00000000
20 00000000 00100093
20 00000004 00200113
20 00000008 00308193
20 0000000c 00410213
// Test 2: compressed and split instructions
10 00000010 00000000
20 00000010 00004501
20 00000012 00b50533
20 00000016 00008082
20 00000018 00000013
20 0000001c 00000001
20 0000001e 00004585
// Test 3: upper-halfword target
10 00000022 00000000
20 00000022 00004605
20 00000024 00c58633
20 00000028 00004681
20 0000002a 00008082
// Test 4: short run, next branch hits requests in flight
10 00000004 00000000
20 00000004 00200113
// Test 5: random back-pressure
11 00000010 00000000
20 00000010 00004501
20 00000012 00b50533
20 00000016 00008082
20 00000018 00000013
20 0000001c 00000001
20 0000001e 00004585
20 00000020 46051117
20 00000024 00c58633
// Test 6: split instruction with a faulty second half
10 00000032 00000000
20 00000032 00100293
20 00000036 00004705
20 00000038 00000013
20 0000003c 00004501
20 0000003e 00008082
ff 00000000 00000000

// File: dv/albuf_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench of the instruction alignment buffer
// Clock and reset, prefetcher model with two-cycle latency,
// pattern file loading, decode rule, compare tasks and timeout
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "albuf_defines.svh"

module albuf_tb import albuf_pkg::*; ();

  localparam int MEM_WORDS = 64;
  localparam int PAT_SIZE  = 512;
  localparam int MAX_TESTS = 16;
  localparam int MAX_EXP   = 128;

  logic  clk;
  logic  rst_n;
  logic  instr_req_i, branch_i, kill_i;
  addr_t branch_addr_i;
  logic  fetch_valid_o, fetch_ready_i, fetch_branch_o;
  addr_t fetch_branch_addr_o;
  logic  resp_valid_i, resp_err_i;
  word_t resp_rdata_i;
  logic  instr_valid_o, instr_ready_i, instr_err_o;
  word_t instr_rdata_o;
  addr_t instr_addr_o;
  logic  prefetch_busy_o;
  ptr_t  outstnd_cnt_o;

  // Raw records of three columns each
  logic [31:0] pat [PAT_SIZE];
  // Memory image seen by the prefetcher
  word_t mem_data [MEM_WORDS];
  logic  mem_err  [MEM_WORDS];
  // Test table and expected instruction list
  addr_t test_tgt   [MAX_TESTS];
  logic  test_rand  [MAX_TESTS];
  int    test_first [MAX_TESTS];
  int    test_len   [MAX_TESTS];
  addr_t exp_addr   [MAX_EXP];
  word_t exp_instr  [MAX_EXP];

  int     num_tests, num_exp, err_cnt, check_cnt;
  int     cycle_cnt;
  int     cycle_limit = 0;
  integer seed;
  // Requests accepted by the prefetcher and not yet answered
  int     model_outst;

  albuf_top u_albuf_top (
    .clk                 (clk),
    .rst_n               (rst_n),
    .instr_req_i         (instr_req_i),
    .branch_i            (branch_i),
    .branch_addr_i       (branch_addr_i),
    .kill_i              (kill_i),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_ready_i       (fetch_ready_i),
    .fetch_branch_o      (fetch_branch_o),
    .fetch_branch_addr_o (fetch_branch_addr_o),
    .resp_valid_i        (resp_valid_i),
    .resp_rdata_i        (resp_rdata_i),
    .resp_err_i          (resp_err_i),
    .instr_valid_o       (instr_valid_o),
    .instr_ready_i       (instr_ready_i),
    .instr_rdata_o       (instr_rdata_o),
    .instr_err_o         (instr_err_o),
    .instr_addr_o        (instr_addr_o),
    .prefetch_busy_o     (prefetch_busy_o),
    .outstnd_cnt_o       (outstnd_cnt_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Memory access and decode rule
  //////////////////////////////////////////////////////////////////////

  // Fill for words outside the image scrambles the full address
  function automatic word_t fill_word(addr_t a);
    return (a * 32'h9e3779b1) ^ 32'h00000013;
  endfunction

  function automatic word_t mem_word(addr_t a);
    if (a[31:2] < MEM_WORDS) return mem_data[a[31:2]];
    return fill_word({a[31:2], 2'b00});
  endfunction

  function automatic logic mem_flag(addr_t a);
    if (a[31:2] < MEM_WORDS) return mem_err[a[31:2]];
    return 1'b0;
  endfunction

  function automatic logic [15:0] halfword(addr_t a);
    word_t w;
    w = mem_word(a);
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // Compressed when the low two bits are not both one
  function automatic word_t rule_instr(addr_t a);
    logic [15:0] lo;
    lo = halfword(a);
    if (lo[1:0] != 2'b11) return {16'h0000, lo};
    return {halfword(a + 32'd2), lo};
  endfunction

  // OR of the flags of every word touched
  function automatic logic rule_err(addr_t a);
    logic [15:0] lo;
    lo = halfword(a);
    if (lo[1:0] != 2'b11) return mem_flag(a);
    return mem_flag(a) | mem_flag(a + 32'd2);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_instr(input word_t got, input word_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR at %0t ns: instruction %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR at %0t ns: address %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR at %0t ns: bus error flag %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_outst(input ptr_t got, input ptr_t exp);
    check_cnt++;
    if (got !== exp || got > ptr_t'(`ALBUF_MAX_OUTST)) begin
      err_cnt++;
      $display("ERROR at %0t ns: %0d requests outstanding, expected %0d, limit %0d",
               $time, got, exp, `ALBUF_MAX_OUTST);
    end
  endtask

  task automatic check_busy(input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR at %0t ns: prefetch busy %b, expected %b", $time, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Pattern file
  //////////////////////////////////////////////////////////////////////

  task automatic load_patterns();
    int          i;
    logic [31:0] kind;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem_data[i] = fill_word(addr_t'(i * 4));
      mem_err[i]  = 1'b0;
    end
    for (i = 0; i < PAT_SIZE; i++) begin
      pat[i] = '1;
    end
    $readmemh("dv/albuf_patterns.txt", pat);
    num_tests = 0;
    num_exp   = 0;
    i         = 0;
    kind      = pat[0];
    while (kind[7:0] != 8'hff && i + 2 < PAT_SIZE) begin
      case (kind)
        32'h00, 32'h01: begin
          mem_data[int'(pat[i+1] >> 2)] = pat[i+2];
          mem_err[int'(pat[i+1] >> 2)]  = kind[0];
        end
        32'h10, 32'h11: begin
          test_tgt[num_tests]   = pat[i+1];
          test_rand[num_tests]  = kind[0];
          test_first[num_tests] = num_exp;
          test_len[num_tests]   = 0;
          num_tests++;
        end
        32'h20: begin
          exp_addr[num_exp]  = pat[i+1];
          exp_instr[num_exp] = pat[i+2];
          num_exp++;
          test_len[num_tests-1]++;
        end
        default: begin
          err_cnt++;
          $display("Pattern file holds an unknown record kind %h", kind);
        end
      endcase
      i    = i + 3;
      kind = pat[i];
    end
    // Listed instructions must agree with the decode rule
    for (i = 0; i < num_exp; i++) begin
      if (exp_instr[i] !== rule_instr(exp_addr[i])) begin
        err_cnt++;
        $display("Pattern entry at %h does not follow the decode rule", exp_addr[i]);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Prefetcher model
  //////////////////////////////////////////////////////////////////////

  // Request in cycle c answers in cycle c+2 in order
  initial begin : prefetcher
    logic  take, redirect, pend_v;
    addr_t redirect_addr, pend_a, pf_addr;
    resp_valid_i = 1'b0;
    resp_rdata_i = '0;
    resp_err_i   = 1'b0;
    pend_v       = 1'b0;
    pend_a       = '0;
    pf_addr      = '0;
    model_outst  = 0;
    forever begin
      @(negedge clk);
      take          = fetch_valid_o && fetch_ready_i;
      redirect      = fetch_branch_o;
      redirect_addr = fetch_branch_addr_o;
      @(posedge clk);
      #1;
      // Last cycle's acceptance and response strobe
      model_outst  = model_outst + int'(take) - int'(resp_valid_i);
      resp_valid_i = pend_v;
      resp_rdata_i = pend_v ? mem_word(pend_a) : '0;
      resp_err_i   = pend_v ? mem_flag(pend_a) : 1'b0;
      // Restart at the word holding the target
      if (redirect) begin
        pf_addr = {redirect_addr[31:2], 2'b00};
      end
      pend_v = take;
      pend_a = pf_addr;
      if (take) begin
        pf_addr = pf_addr + 32'd4;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  // Entered and left 1 ns after a rising edge
  task automatic run_test(input int t);
    int          idx;
    int          k;
    int          errs_before;
    logic [31:0] rnd;
    errs_before   = err_cnt;
    idx           = 0;
    // Redirect with kill as the controller does
    instr_req_i   = 1'b1;
    branch_i      = 1'b1;
    kill_i        = 1'b1;
    branch_addr_i = test_tgt[t];
    while (idx < test_len[t]) begin
      @(negedge clk);
      check_outst(outstnd_cnt_o, ptr_t'(model_outst));
      check_busy(prefetch_busy_o, (model_outst != 0) || (fetch_valid_o === 1'b1));
      if (instr_valid_o === 1'b1 && instr_ready_i) begin
        k = test_first[t] + idx;
        check_addr(instr_addr_o, exp_addr[k]);
        check_instr(instr_rdata_o, exp_instr[k]);
        check_err(instr_err_o, rule_err(exp_addr[k]));
        idx++;
      end
      @(posedge clk);
      #1;
      branch_i = 1'b0;
      kill_i   = 1'b0;
      rnd      = $random(seed);
      instr_ready_i = test_rand[t] ? rnd[0] : 1'b1;
    end
    $display("Test %0d: target %h, %0d instructions, %s ready, %0d errors",
             t + 1, test_tgt[t], test_len[t], test_rand[t] ? "random" : "full",
             err_cnt - errs_before);
  endtask

  initial begin : main
    int t;
    rst_n         = 1'b0;
    instr_req_i   = 1'b0;
    branch_i      = 1'b0;
    kill_i        = 1'b0;
    branch_addr_i = '0;
    fetch_ready_i = 1'b1;
    instr_ready_i = 1'b1;
    seed          = 32'h7ac2;
    err_cnt       = 0;
    check_cnt     = 0;
    load_patterns();
    cycle_limit = 200 * num_tests + 50;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    for (t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    if (num_tests == 0) begin
      err_cnt++;
      $display("No tests were found in the pattern file");
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", num_tests, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog over the whole run
  initial begin : watchdog
    cycle_cnt = 0;
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: files.f
+incdir+hdl
hdl/albuf_pkg.sv
hdl/albuf_fetch_ctrl.sv
hdl/albuf_ins_tracker.sv
hdl/albuf_fifo.sv
hdl/albuf_realign.sv
hdl/albuf_top.sv
dv/albuf_tb.sv

// File: hdl/albuf_defines.svh
//////////////////////////////////////////////////////////////////////
// Sizing macros for the instruction alignment buffer
// FIFO depth, pointer and counter widths, outstanding request limit
//////////////////////////////////////////////////////////////////////

`ifndef ALBUF_DEFINES_SVH
`define ALBUF_DEFINES_SVH

// Number of response words the FIFO can hold
`define ALBUF_DEPTH 3

// Read/write pointer width, also used for the outstanding count
`define ALBUF_PTR_W 2

// Buffered instruction counter, up to two instructions per entry
`define ALBUF_CNT_W 3

// Requests allowed in flight towards the prefetcher
`define ALBUF_MAX_OUTST 2

`endif

// File: hdl/albuf_fetch_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Fetch control of the alignment buffer
// Request decision, outstanding and instruction counters,
// flush counter for stale responses and response gating
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "albuf_defines.svh"

module albuf_fetch_ctrl import albuf_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  instr_req_i,
  input  logic  branch_i,
  input  logic  kill_i,
  input  logic  fetch_ready_i,
  input  logic  resp_valid_i,
  input  logic  instr_valid_i,
  input  logic  instr_ready_i,
  input  nins_t n_incoming_i,
  output logic  fetch_valid_o,
  output logic  prefetch_busy_o,
  output logic  resp_accept_o,
  output ptr_t  outstnd_cnt_o
);

  // Requests sent but not yet answered
  ptr_t  outst_q, outst_n;
  // Complete instructions in the FIFO
  icnt_t icnt_q, icnt_n;
  // Count corrected by last cycle's emission
  icnt_t icnt_avail;
  // An instruction left the buffer last cycle
  logic  pop_q;
  // Stale responses still to be dropped
  ptr_t  flush_q, flush_n;
  logic  req_fire;

  //////////////////////////////////////////////////////////////////////
  // Request decision
  //////////////////////////////////////////////////////////////////////

  // Emission is subtracted one cycle late to keep instr_ready_i off this path
  assign icnt_avail = icnt_q - icnt_t'(pop_q);

  // Fetch when the buffer runs dry, or on a redirect
  assign fetch_valid_o = instr_req_i &&
                         (outst_q < ptr_t'(`ALBUF_MAX_OUTST)) &&
                         ((icnt_avail == '0) ||
                          ((icnt_avail == icnt_t'(1)) && (outst_q == '0)) ||
                          branch_i);

  assign req_fire        = fetch_valid_o && fetch_ready_i;
  assign prefetch_busy_o = (outst_q != '0) || fetch_valid_o;

  // Responses of the old stream never reach the FIFO
  assign resp_accept_o = resp_valid_i && (flush_q == '0);

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  // Outstanding: up on accepted request, down on every response strobe
  always_comb begin
    outst_n = outst_q;
    case ({req_fire, resp_valid_i})
      2'b10:   outst_n = outst_q + ptr_t'(1);
      2'b01:   outst_n = outst_q - ptr_t'(1);
      default: outst_n = outst_q;
    endcase
  end

  // Kill empties the buffer; otherwise add pushed, subtract popped
  always_comb begin
    if (kill_i) begin
      icnt_n = '0;
    end else begin
      icnt_n = icnt_q + icnt_t'(n_incoming_i) - icnt_t'(pop_q);
    end
  end

  // On a branch all in-flight words are stale,
  // except one that arrives in the branch cycle itself
  always_comb begin
    flush_n = flush_q;
    if (branch_i) begin
      flush_n = outst_q - ptr_t'(resp_valid_i);
    end else if (resp_valid_i && (flush_q != '0)) begin
      flush_n = flush_q - ptr_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_q <= '0;
      icnt_q  <= '0;
      pop_q   <= 1'b0;
      flush_q <= '0;
    end else begin
      outst_q <= outst_n;
      icnt_q  <= icnt_n;
      pop_q   <= instr_valid_i && instr_ready_i;
      flush_q <= flush_n;
    end
  end

  assign outstnd_cnt_o = outst_q;

endmodule

// File: hdl/albuf_fifo.sv
//////////////////////////////////////////////////////////////////////
// Response FIFO of the alignment buffer
// Circular storage of words and error flags, head and next views
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "albuf_defines.svh"

module albuf_fifo import albuf_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  branch_i,
  input  logic  kill_i,
  input  logic  resp_accept_i,
  input  logic  advance_i,
  input  logic  consume_i,
  input  word_t resp_rdata_i,
  input  logic  resp_err_i,
  output logic  head_valid_o,
  output logic  next_valid_o,
  output word_t head_rdata_o,
  output word_t next_rdata_o,
  output logic  head_err_o,
  output logic  next_err_o
);

  word_t                 data_q [`ALBUF_DEPTH];
  logic [`ALBUF_DEPTH-1:0] err_q;
  logic [`ALBUF_DEPTH-1:0] valid_q, valid_n;
  ptr_t                  wptr_q, rptr_q, rptr2;
  // Head word fully used by the instruction taken this cycle
  logic                  head_done;

  // Increment with wraparound over the depth
  function automatic ptr_t ptr_inc(ptr_t p);
    return (p == ptr_t'(`ALBUF_DEPTH - 1)) ? ptr_t'(0) : p + ptr_t'(1);
  endfunction

  assign rptr2     = ptr_inc(rptr_q);
  assign head_done = advance_i && consume_i;

  // Read side
  assign head_valid_o = valid_q[rptr_q];
  assign head_rdata_o = data_q[rptr_q];
  assign head_err_o   = err_q[rptr_q];
  assign next_valid_o = valid_q[rptr2];
  assign next_rdata_o = data_q[rptr2];
  assign next_err_o   = err_q[rptr2];

  // Set on write, then clear on consume; clear wins for a pass-through word
  always_comb begin
    valid_n = valid_q;
    if (resp_accept_i) begin
      valid_n[wptr_q] = 1'b1;
    end
    if (head_done) begin
      valid_n[rptr_q] = 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (resp_accept_i && !kill_i) begin
      data_q[wptr_q] <= resp_rdata_i;
      err_q[wptr_q]  <= resp_err_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else begin
      valid_q <= kill_i ? '0 : valid_n;
      if (branch_i) begin
        // New stream fills from entry 0
        wptr_q <= '0;
        rptr_q <= '0;
      end else begin
        if (resp_accept_i) begin
          wptr_q <= ptr_inc(wptr_q);
        end
        if (head_done) begin
          rptr_q <= rptr2;
        end
      end
    end
  end

endmodule

// File: hdl/albuf_ins_tracker.sv
//////////////////////////////////////////////////////////////////////
// Write-side instruction tracker
// Counts complete instructions in each accepted response word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module albuf_ins_tracker import albuf_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  branch_i,
  input  logic  resp_accept_i,
  input  addr_t branch_addr_i,
  input  word_t resp_rdata_i,
  output nins_t n_incoming_o
);

  align_state_e state_q, state_n;
  // Compressed markers of the lower and upper halfword
  logic lo_c;
  logic hi_c;

  assign lo_c = resp_rdata_i[1:0] != 2'b11;
  assign hi_c = resp_rdata_i[17:16] != 2'b11;

  always_comb begin
    state_n      = state_q;
    n_incoming_o = 2'd0;
    if (branch_i) begin
      // Upper halfword target skips the lower half of the first word
      state_n = branch_addr_i[1] ? UNALIGNED_BRANCH : ALIGNED;
    end else if (resp_accept_i) begin
      case (state_q)
        ALIGNED: begin
          if (!lo_c) begin
            // Full 32-bit instruction, still aligned
            n_incoming_o = 2'd1;
          end else if (!hi_c) begin
            // Compressed, then start of a split one
            n_incoming_o = 2'd1;
            state_n      = UNALIGNED_SPLIT;
          end else begin
            n_incoming_o = 2'd2;
          end
        end
        UNALIGNED_BRANCH: begin
          // Lower half is dropped, only upper half counts
          n_incoming_o = hi_c ? 2'd1 : 2'd0;
          state_n      = hi_c ? ALIGNED : UNALIGNED_SPLIT;
        end
        UNALIGNED_SPLIT: begin
          // Lower half completes the pending instruction
          n_incoming_o = hi_c ? 2'd2 : 2'd1;
          state_n      = hi_c ? ALIGNED : UNALIGNED_SPLIT;
        end
        default: state_n = ALIGNED;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGNED;
    end else begin
      state_q <= state_n;
    end
  end

endmodule

// File: hdl/albuf_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types of the alignment buffer
// Vector typedefs and the write-side alignment state
//////////////////////////////////////////////////////////////////////

`include "albuf_defines.svh"

package albuf_pkg;

  // Byte address and fetched or assembled word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // FIFO pointer, also the outstanding request count
  typedef logic [`ALBUF_PTR_W-1:0] ptr_t;

  // Complete instructions held in the buffer
  typedef logic [`ALBUF_CNT_W-1:0] icnt_t;

  // Complete instructions found in one response, 0 to 2
  typedef logic [1:0] nins_t;

  // Where the next written word starts relative to an instruction
  typedef enum logic [1:0] {
    ALIGNED          = 2'b00,
    UNALIGNED_BRANCH = 2'b01,
    UNALIGNED_SPLIT  = 2'b10
  } align_state_e;

endpackage

// File: hdl/albuf_realign.sv
//////////////////////////////////////////////////////////////////////
// Output realignment of the alignment buffer
// Current address, aligned and split instruction assembly,
// merged bus error and FIFO read control
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module albuf_realign import albuf_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  branch_i,
  input  logic  kill_i,
  input  logic  instr_ready_i,
  input  logic  resp_accept_i,
  input  addr_t branch_addr_i,
  input  word_t resp_rdata_i,
  input  logic  resp_err_i,
  input  logic  head_valid_i,
  input  logic  next_valid_i,
  input  word_t head_rdata_i,
  input  word_t next_rdata_i,
  input  logic  head_err_i,
  input  logic  next_err_i,
  output logic  instr_valid_o,
  output word_t instr_rdata_o,
  output logic  instr_err_o,
  output addr_t instr_addr_o,
  output logic  advance_o,
  output logic  consume_o
);

  addr_t addr_q, addr_n, addr_incr;
  word_t word_cur, word_split;
  logic  err_cur, err_split;
  logic  valid_cur, valid_split;
  logic  aligned_c, unaligned_c;

  // Head word if buffered, else the word arriving now
  assign word_cur = head_valid_i ? head_rdata_i : resp_rdata_i;
  assign err_cur  = head_valid_i ? head_err_i : resp_err_i;

  // Upper half of current word joined with lower half of the following one
  assign word_split = next_valid_i ? {next_rdata_i[15:0], word_cur[31:16]}
                                   : {resp_rdata_i[15:0], word_cur[31:16]};
  assign err_split  = err_cur | (next_valid_i ? next_err_i : resp_err_i);

  assign valid_cur   = head_valid_i || resp_accept_i;
  assign valid_split = next_valid_i || (head_valid_i && resp_accept_i);

  assign aligned_c   = word_cur[1:0] != 2'b11;
  assign unaligned_c = word_cur[17:16] != 2'b11;

  always_comb begin
    instr_rdata_o = word_cur;
    instr_err_o   = err_cur;
    instr_valid_o = 1'b0;
    if (kill_i) begin
      instr_valid_o = 1'b0;
    end else if (addr_q[1]) begin
      if (unaligned_c) begin
        instr_rdata_o = {16'h0000, word_cur[31:16]};
        instr_valid_o = valid_cur;
      end else begin
        // Needs both words
        instr_rdata_o = word_split;
        instr_err_o   = err_split;
        instr_valid_o = valid_split;
      end
    end else begin
      if (aligned_c) begin
        instr_rdata_o = {16'h0000, word_cur[15:0]};
      end
      instr_valid_o = valid_cur;
    end
  end

  // Everything except an aligned compressed instruction finishes the word
  assign consume_o = addr_q[1] || !aligned_c;
  assign advance_o = instr_valid_o && instr_ready_i;

  assign addr_incr = {addr_q[31:2], 2'b00} + 32'h4;

  always_comb begin
    if (!consume_o) begin
      addr_n = {addr_q[31:2], 2'b10};
    end else if (addr_q[1] && !unaligned_c) begin
      // Split instruction ends in the lower half of the next word
      addr_n = {addr_incr[31:2], 2'b10};
    end else begin
      addr_n = {addr_incr[31:2], 2'b00};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (branch_i) begin
      addr_q <= branch_addr_i;
    end else if (advance_o) begin
      addr_q <= addr_n;
    end
  end

  assign instr_addr_o = addr_q;

endmodule

// File: hdl/albuf_top.sv
//////////////////////////////////////////////////////////////////////
// Instruction alignment buffer, top level
// Fetch control, tracker, FIFO and realignment wired together
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module albuf_top import albuf_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // Controller
  input  logic  instr_req_i,
  input  logic  branch_i,
  input  addr_t branch_addr_i,
  input  logic  kill_i,
  // Prefetcher request side
  output logic  fetch_valid_o,
  input  logic  fetch_ready_i,
  output logic  fetch_branch_o,
  output addr_t fetch_branch_addr_o,
  // Prefetcher response side
  input  logic  resp_valid_i,
  input  word_t resp_rdata_i,
  input  logic  resp_err_i,
  // Instruction output
  output logic  instr_valid_o,
  input  logic  instr_ready_i,
  output word_t instr_rdata_o,
  output logic  instr_err_o,
  output addr_t instr_addr_o,
  // Status
  output logic  prefetch_busy_o,
  output ptr_t  outstnd_cnt_o
);

  logic  resp_accept;
  nins_t n_incoming;
  logic  head_valid, next_valid, head_err, next_err;
  word_t head_rdata, next_rdata;
  logic  advance, consume;

  // Prefetcher restarts at the halfword-aligned target
  assign fetch_branch_o      = branch_i;
  assign fetch_branch_addr_o = {branch_addr_i[31:1], 1'b0};

  albuf_fetch_ctrl u_fetch_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_req_i     (instr_req_i),
    .branch_i        (branch_i),
    .kill_i          (kill_i),
    .fetch_ready_i   (fetch_ready_i),
    .resp_valid_i    (resp_valid_i),
    .instr_valid_i   (instr_valid_o),
    .instr_ready_i   (instr_ready_i),
    .n_incoming_i    (n_incoming),
    .fetch_valid_o   (fetch_valid_o),
    .prefetch_busy_o (prefetch_busy_o),
    .resp_accept_o   (resp_accept),
    .outstnd_cnt_o   (outstnd_cnt_o)
  );

  albuf_ins_tracker u_ins_tracker (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .resp_accept_i (resp_accept),
    .branch_addr_i (branch_addr_i),
    .resp_rdata_i  (resp_rdata_i),
    .n_incoming_o  (n_incoming)
  );

  albuf_fifo u_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .kill_i        (kill_i),
    .resp_accept_i (resp_accept),
    .advance_i     (advance),
    .consume_i     (consume),
    .resp_rdata_i  (resp_rdata_i),
    .resp_err_i    (resp_err_i),
    .head_valid_o  (head_valid),
    .next_valid_o  (next_valid),
    .head_rdata_o  (head_rdata),
    .next_rdata_o  (next_rdata),
    .head_err_o    (head_err),
    .next_err_o    (next_err)
  );

  albuf_realign u_realign (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .kill_i        (kill_i),
    .instr_ready_i (instr_ready_i),
    .resp_accept_i (resp_accept),
    .branch_addr_i (branch_addr_i),
    .resp_rdata_i  (resp_rdata_i),
    .resp_err_i    (resp_err_i),
    .head_valid_i  (head_valid),
    .next_valid_i  (next_valid),
    .head_rdata_i  (head_rdata),
    .next_rdata_i  (next_rdata),
    .head_err_i    (head_err),
    .next_err_i    (next_err),
    .instr_valid_o (instr_valid_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_err_o   (instr_err_o),
    .instr_addr_o  (instr_addr_o),
    .advance_o     (advance),
    .consume_o     (consume)
  );

endmodule
